/* hw/sdp_wdma_settings.svh */
// ====================
// sdp write-DMA settings
// widths and queue depths shared by the write-DMA stage
// ====================
`ifndef SDP_WDMA_SETTINGS_SVH
`define SDP_WDMA_SETTINGS_SVH

// ====================
// datapath widths
// ====================

// address in 8-byte atom units
`define SDP_WDMA_ADDR_W 29

// width, height and channel fields, minus-one encoded
`define SDP_WDMA_DIM_W 13

// one atom holds eight 8-bit channels
`define SDP_WDMA_DATA_W 64

// ====================
// queue depths
// ====================

// line commands buffered between cmd and dat
`define SDP_WDMA_CMD_DEPTH 4

// write packets waiting for memory
`define SDP_WDMA_REQ_DEPTH 2

`endif

/* hw/sdp_wdma_pkg.sv */
// ====================
// sdp write-DMA types
// address, dimension, atom, line command and
// memory write packet formats
// ====================
`include "sdp_wdma_settings.svh"

package sdp_wdma_pkg;

  typedef logic [`SDP_WDMA_ADDR_W-1:0] dma_addr_t;  // atom-unit address
  typedef logic [`SDP_WDMA_DIM_W-1:0]  dim_t;       // minus-one dimension
  typedef logic [`SDP_WDMA_DATA_W-1:0] atom_t;      // 8 channels x 8 bits

  // ====================
  // one line of the output cube
  // ====================
  typedef struct packed {
    logic      last;  // final line of the cube
    dim_t      size;  // atoms minus one
    dma_addr_t addr;
  } line_cmd_t;

  // ====================
  // memory write packet
  // ====================
  // command payload: addr in [28:0], size in [41:29], upper bits zero
  typedef struct packed {
    logic  kind;     // 0 command, 1 data
    logic  ack;      // ask memory for a completion
    atom_t payload;
  } wr_req_t;

  localparam logic req_kind_cmd = 1'b0;
  localparam logic req_kind_dat = 1'b1;

endpackage

/* hw/sdp_wdma_fifo.sv */
// ====================
// generic valid/ready FIFO
// circular buffer with a type parameter, serves the
// line command queue and the memory request stage
// ====================
`timescale 1ns/1ps

module sdp_wdma_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 2
) (
  input  logic     autosa_core_clk,
  input  logic     autosa_core_rstn,
  input  logic     wr_valid,
  output logic     wr_ready,
  input  payload_t wr_data,
  output logic     rd_valid,
  input  logic     rd_ready,
  output payload_t rd_data
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t           mem [depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               push;
  logic               pop;

  assign wr_ready = (count != cnt_w'(depth));  // full holds off writer
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];
  assign push     = wr_valid & wr_ready;
  assign pop      = rd_valid & rd_ready;

  always_ff @(posedge autosa_core_clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  a_count_bound : assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    count <= cnt_w'(depth));

  // head entry must not move while the reader stalls
  a_rd_hold : assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    rd_valid && !rd_ready |=> rd_valid && $stable(rd_data));

endmodule

/* hw/sdp_wdma_cmd.sv */
// ====================
// write-DMA command generator
// walks surfaces then lines of the output cube and
// issues one line command per line
// ====================
`timescale 1ns/1ps

module sdp_wdma_cmd (
  input  logic                    autosa_core_clk,
  input  logic                    autosa_core_rstn,
  input  logic                    op_load,
  input  sdp_wdma_pkg::dma_addr_t reg2dp_dst_base_addr,
  input  sdp_wdma_pkg::dma_addr_t reg2dp_dst_line_stride,
  input  sdp_wdma_pkg::dma_addr_t reg2dp_dst_surface_stride,
  input  sdp_wdma_pkg::dim_t      reg2dp_width,
  input  sdp_wdma_pkg::dim_t      reg2dp_height,
  input  sdp_wdma_pkg::dim_t      reg2dp_channel,
  output logic                    cmd_valid,
  output sdp_wdma_pkg::line_cmd_t cmd_pd,
  input  logic                    cmd_ready
);
  import sdp_wdma_pkg::*;

  dma_addr_t line_stride_q;
  dma_addr_t surf_stride_q;
  dim_t      width_q;
  dim_t      height_q;
  dim_t      surf_last_q;  // surfaces minus one
  logic      busy;
  dim_t      line_cnt;
  dim_t      surf_cnt;
  dma_addr_t line_addr;    // address of current line
  dma_addr_t surf_addr;    // base of current surface
  dma_addr_t next_surf_addr;
  logic      last_line;
  logic      last_surf;
  logic      cmd_fire;

  // ====================
  // config latch
  // ====================
  always_ff @(posedge autosa_core_clk) begin
    if (op_load) begin
      line_stride_q <= reg2dp_dst_line_stride;
      surf_stride_q <= reg2dp_dst_surface_stride;
      width_q       <= reg2dp_width;
      height_q      <= reg2dp_height;
      surf_last_q   <= reg2dp_channel >> 3;  // 8 channels per surface
    end
  end

  assign last_line      = (line_cnt == height_q);
  assign last_surf      = (surf_cnt == surf_last_q);
  assign next_surf_addr = surf_addr + surf_stride_q;
  assign cmd_fire       = cmd_valid & cmd_ready;

  assign cmd_valid   = busy;
  assign cmd_pd.addr = line_addr;
  assign cmd_pd.size = width_q;
  assign cmd_pd.last = last_line & last_surf;

  // ====================
  // line / surface walk
  // ====================
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      busy      <= 1'b0;
      line_cnt  <= '0;
      surf_cnt  <= '0;
      line_addr <= '0;
      surf_addr <= '0;
    end else if (op_load) begin
      busy      <= 1'b1;
      line_cnt  <= '0;
      surf_cnt  <= '0;
      line_addr <= reg2dp_dst_base_addr;
      surf_addr <= reg2dp_dst_base_addr;
    end else if (cmd_fire) begin
      if (!last_line) begin
        line_cnt  <= line_cnt + 1'b1;
        line_addr <= line_addr + line_stride_q;  // next line, same surface
      end else if (!last_surf) begin
        line_cnt  <= '0;
        surf_cnt  <= surf_cnt + 1'b1;
        surf_addr <= next_surf_addr;
        line_addr <= next_surf_addr;
      end else begin
        busy <= 1'b0;  // cube done
      end
    end
  end

  // top level may only start a new cube once the walk has finished
  a_load_idle : assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    op_load |-> !busy);

endmodule

/* hw/sdp_wdma_dat.sv */
// ====================
// write-DMA data packer
// turns each line command into a command packet
// followed by its data beats from the input stream
// ====================
`timescale 1ns/1ps

module sdp_wdma_dat (
  input  logic                    autosa_core_clk,
  input  logic                    autosa_core_rstn,
  input  logic                    op_load,
  input  logic                    reg2dp_interrupt_ptr,
  input  logic                    cmd_valid,
  input  sdp_wdma_pkg::line_cmd_t cmd_pd,
  output logic                    cmd_ready,
  input  logic                    sdp_dp2wdma_valid,
  input  sdp_wdma_pkg::atom_t     sdp_dp2wdma_pd,
  output logic                    sdp_dp2wdma_ready,
  output logic                    req_valid,
  output sdp_wdma_pkg::wr_req_t   req_pd,
  input  logic                    req_ready,
  output logic                    intr_req_pvld,
  output logic                    intr_req_ptr
);
  import sdp_wdma_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_cmd,
    st_data
  } state_t;

  state_t    state;
  line_cmd_t cmd_q;
  dim_t      beat_cnt;
  logic      ptr_q;
  logic      beat_push;
  logic      beat_last;

  assign cmd_ready         = (state == st_idle);
  assign sdp_dp2wdma_ready = (state == st_data) & req_ready;  // room downstream
  assign beat_push         = sdp_dp2wdma_valid & sdp_dp2wdma_ready;
  assign beat_last         = (beat_cnt == cmd_q.size);
  assign intr_req_pvld     = beat_push & beat_last & cmd_q.last;
  assign intr_req_ptr      = ptr_q;

  // ====================
  // packet mux
  // ====================
  always_comb begin
    req_valid = 1'b0;
    req_pd    = '0;
    case (state)
      st_cmd: begin
        req_valid      = 1'b1;
        req_pd.kind    = req_kind_cmd;
        req_pd.ack     = cmd_q.last;  // completion only for final line
        req_pd.payload = atom_t'({cmd_q.size, cmd_q.addr});
      end
      st_data: begin
        req_valid      = sdp_dp2wdma_valid;
        req_pd.kind    = req_kind_dat;
        req_pd.payload = sdp_dp2wdma_pd;
      end
      default: begin
        req_valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge autosa_core_clk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_q <= cmd_pd;
    end
  end

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      state    <= st_idle;
      beat_cnt <= '0;
      ptr_q    <= 1'b0;
    end else begin
      if (op_load) begin
        ptr_q <= reg2dp_interrupt_ptr;
      end
      case (state)
        st_idle: begin
          if (cmd_valid) begin
            state <= st_cmd;
          end
        end
        st_cmd: begin
          if (req_ready) begin
            state    <= st_data;
            beat_cnt <= '0;
          end
        end
        st_data: begin
          if (beat_push) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_last) begin
              state <= st_idle;  // line complete
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data beats never run past the size of the line
  a_data_phase : assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    beat_push |-> beat_cnt <= cmd_q.size);

endmodule

/* hw/sdp_wdma_intr.sv */
// ====================
// write-DMA completion and interrupt
// joins the data-sent and memory-complete events into
// done plus a ping-pong interrupt, counts memory stalls
// ====================
`timescale 1ns/1ps

module sdp_wdma_intr (
  input  logic        autosa_core_clk,
  input  logic        autosa_core_rstn,
  input  logic        op_load,
  input  logic        processing,
  input  logic        reg2dp_perf_dma_en,
  input  logic        intr_req_pvld,
  input  logic        intr_req_ptr,
  input  logic        mcif2sdp_wr_rsp_complete,
  input  logic        req_valid,
  input  logic        req_ready,
  output logic        dp2reg_done,
  output logic [1:0]  sdp2glb_done_intr_pd,
  output logic [31:0] dp2reg_wdma_stall
);

  logic data_sent;  // last beat queued
  logic completed;  // memory ack seen
  logic ptr_q;
  logic stall;

  assign dp2reg_done          = data_sent & completed;
  assign sdp2glb_done_intr_pd = {dp2reg_done & ptr_q, dp2reg_done & ~ptr_q};

  // ====================
  // event join
  // ====================
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      data_sent <= 1'b0;
      completed <= 1'b0;
      ptr_q     <= 1'b0;
    end else if (dp2reg_done) begin
      data_sent <= 1'b0;
      completed <= 1'b0;
    end else begin
      if (intr_req_pvld) begin
        data_sent <= 1'b1;
        ptr_q     <= intr_req_ptr;
      end
      if (mcif2sdp_wr_rsp_complete) begin
        completed <= 1'b1;
      end
    end
  end

  // ====================
  // stall counter
  // ====================
  assign stall = processing & reg2dp_perf_dma_en & req_valid & ~req_ready;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      dp2reg_wdma_stall <= '0;
    end else if (op_load) begin
      dp2reg_wdma_stall <= '0;
    end else if (stall && dp2reg_wdma_stall != '1) begin
      dp2reg_wdma_stall <= dp2reg_wdma_stall + 1'b1;  // saturates
    end
  end

  a_rsp_in_op : assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    mcif2sdp_wr_rsp_complete |-> processing);

endmodule

/* hw/sdp_wdma.sv */
// ====================
// sdp write-DMA top
// operation latch, command generator, command queue,
// data packer, request stage and interrupt block
// ====================
`timescale 1ns/1ps
`include "sdp_wdma_settings.svh"

module sdp_wdma (
  input  logic                    autosa_core_clk,
  input  logic                    autosa_core_rstn,
  input  logic                    reg2dp_op_en,
  input  sdp_wdma_pkg::dma_addr_t reg2dp_dst_base_addr,
  input  sdp_wdma_pkg::dma_addr_t reg2dp_dst_line_stride,
  input  sdp_wdma_pkg::dma_addr_t reg2dp_dst_surface_stride,
  input  sdp_wdma_pkg::dim_t      reg2dp_width,
  input  sdp_wdma_pkg::dim_t      reg2dp_height,
  input  sdp_wdma_pkg::dim_t      reg2dp_channel,
  input  logic                    reg2dp_interrupt_ptr,
  input  logic                    reg2dp_perf_dma_en,
  input  logic                    sdp_dp2wdma_valid,
  input  sdp_wdma_pkg::atom_t     sdp_dp2wdma_pd,
  output logic                    sdp_dp2wdma_ready,
  output logic                    sdp2mcif_wr_req_valid,
  output sdp_wdma_pkg::wr_req_t   sdp2mcif_wr_req_pd,
  input  logic                    sdp2mcif_wr_req_ready,
  input  logic                    mcif2sdp_wr_rsp_complete,
  output logic                    dp2reg_done,
  output logic [31:0]             dp2reg_status_wdma_stall,
  output logic [1:0]              sdp2glb_done_intr_pd
);
  import sdp_wdma_pkg::*;

  logic      processing;
  logic      op_load;
  logic      cmd_valid;
  logic      cmd_ready;
  line_cmd_t cmd_pd;
  logic      q_valid;    // queue to packer
  logic      q_ready;
  line_cmd_t q_pd;
  logic      req_valid;  // packer to request stage
  logic      req_ready;
  wr_req_t   req_pd;
  logic      intr_req_pvld;
  logic      intr_req_ptr;

  // ====================
  // operation latch
  // ====================
  assign op_load = reg2dp_op_en & ~processing;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      processing <= 1'b0;
    end else if (op_load) begin
      processing <= 1'b1;
    end else if (dp2reg_done) begin
      processing <= 1'b0;
    end
  end

  sdp_wdma_cmd u_cmd (
    .autosa_core_clk           (autosa_core_clk),
    .autosa_core_rstn          (autosa_core_rstn),
    .op_load                   (op_load),
    .reg2dp_dst_base_addr      (reg2dp_dst_base_addr),
    .reg2dp_dst_line_stride    (reg2dp_dst_line_stride),
    .reg2dp_dst_surface_stride (reg2dp_dst_surface_stride),
    .reg2dp_width              (reg2dp_width),
    .reg2dp_height             (reg2dp_height),
    .reg2dp_channel            (reg2dp_channel),
    .cmd_valid                 (cmd_valid),
    .cmd_pd                    (cmd_pd),
    .cmd_ready                 (cmd_ready)
  );

  sdp_wdma_fifo #(.payload_t(line_cmd_t), .depth(`SDP_WDMA_CMD_DEPTH)) u_cmd_fifo (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .wr_valid         (cmd_valid),
    .wr_ready         (cmd_ready),
    .wr_data          (cmd_pd),
    .rd_valid         (q_valid),
    .rd_ready         (q_ready),
    .rd_data          (q_pd)
  );

  sdp_wdma_dat u_dat (
    .autosa_core_clk      (autosa_core_clk),
    .autosa_core_rstn     (autosa_core_rstn),
    .op_load              (op_load),
    .reg2dp_interrupt_ptr (reg2dp_interrupt_ptr),
    .cmd_valid            (q_valid),
    .cmd_pd               (q_pd),
    .cmd_ready            (q_ready),
    .sdp_dp2wdma_valid    (sdp_dp2wdma_valid),
    .sdp_dp2wdma_pd       (sdp_dp2wdma_pd),
    .sdp_dp2wdma_ready    (sdp_dp2wdma_ready),
    .req_valid            (req_valid),
    .req_pd               (req_pd),
    .req_ready            (req_ready),
    .intr_req_pvld        (intr_req_pvld),
    .intr_req_ptr         (intr_req_ptr)
  );

  // request stage, read side faces memory
  sdp_wdma_fifo #(.payload_t(wr_req_t), .depth(`SDP_WDMA_REQ_DEPTH)) u_req_fifo (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .wr_valid         (req_valid),
    .wr_ready         (req_ready),
    .wr_data          (req_pd),
    .rd_valid         (sdp2mcif_wr_req_valid),
    .rd_ready         (sdp2mcif_wr_req_ready),
    .rd_data          (sdp2mcif_wr_req_pd)
  );

  sdp_wdma_intr u_intr (
    .autosa_core_clk          (autosa_core_clk),
    .autosa_core_rstn         (autosa_core_rstn),
    .op_load                  (op_load),
    .processing               (processing),
    .reg2dp_perf_dma_en       (reg2dp_perf_dma_en),
    .intr_req_pvld            (intr_req_pvld),
    .intr_req_ptr             (intr_req_ptr),
    .mcif2sdp_wr_rsp_complete (mcif2sdp_wr_rsp_complete),
    .req_valid                (sdp2mcif_wr_req_valid),
    .req_ready                (sdp2mcif_wr_req_ready),
    .dp2reg_done              (dp2reg_done),
    .sdp2glb_done_intr_pd     (sdp2glb_done_intr_pd),
    .dp2reg_wdma_stall        (dp2reg_status_wdma_stall)
  );

endmodule

/* bench/sdp_wdma_tb.sv */
// ====================
// sdp write-DMA testbench
// table-driven cubes with random back-pressure on both sides,
// memory-side model with delayed completion, stall count check
// ====================
`timescale 1ns/1ps
`include "sdp_wdma_settings.svh"

module sdp_wdma_tb;
  import sdp_wdma_pkg::*;

  localparam int n_cases = 4;
  localparam int rsp_lag = 3;  // last ack beat to completion, in cycles

  typedef struct packed {
    dma_addr_t base;
    dma_addr_t line_stride;
    dma_addr_t surf_stride;
    dim_t      width;
    dim_t      height;
    dim_t      channel;
    logic      ptr;
    logic      perf;
    logic [6:0] ready_pct;  // memory ready throttle
  } case_t;

  logic        autosa_core_clk;
  logic        autosa_core_rstn;
  logic        reg2dp_op_en;
  dma_addr_t   reg2dp_dst_base_addr;
  dma_addr_t   reg2dp_dst_line_stride;
  dma_addr_t   reg2dp_dst_surface_stride;
  dim_t        reg2dp_width;
  dim_t        reg2dp_height;
  dim_t        reg2dp_channel;
  logic        reg2dp_interrupt_ptr;
  logic        reg2dp_perf_dma_en;
  logic        sdp_dp2wdma_valid;
  atom_t       sdp_dp2wdma_pd;
  logic        sdp_dp2wdma_ready;
  logic        sdp2mcif_wr_req_valid;
  wr_req_t     sdp2mcif_wr_req_pd;
  logic        sdp2mcif_wr_req_ready;
  logic        mcif2sdp_wr_rsp_complete;
  logic        dp2reg_done;
  logic [31:0] dp2reg_status_wdma_stall;
  logic [1:0]  sdp2glb_done_intr_pd;

  case_t       cases [n_cases];
  atom_t       atom_q [$];  // input stream, front is on the bus
  wr_req_t     exp_q [$];   // packets memory should see
  logic [31:0] rng_state;
  logic [6:0]  ready_pct;
  logic        mon_on;
  logic        tb_proc;     // mirror of processing
  logic        prev_complete;
  logic        in_fire;
  int          done_cnt;
  int          stall_model;
  int          ack_left;
  int          rsp_due;
  int          rsp_taken;
  int          rsp_wait;

  sdp_wdma dut0 (.*);

  initial begin
    autosa_core_clk = 1'b0;
    forever #5 autosa_core_clk = ~autosa_core_clk;
  end

  // ====================
  // helpers
  // ====================
  function automatic logic [31:0] xorshift_next();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic tick();
    @(posedge autosa_core_clk);
    #1;
  endtask

  task automatic stop_run(input string what);
    $display("test failed");
    $display("%s at %0t ns", what, $time);
    $fatal(1);
  endtask

  task automatic check_req(input wr_req_t exp, input wr_req_t act, input string name);
    if (act !== exp) begin
      $display("test failed");
      $display("error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      $fatal(1);
    end
  endtask

  task automatic check_count(input logic [31:0] exp, input logic [31:0] act,
                             input string name);
    if (act !== exp) begin
      $display("test failed");
      $display("error at %0t ns: %s expected %0d actual %0d", $time, name, exp, act);
      $fatal(1);
    end
  endtask

  task automatic check_bit(input logic exp, input logic act, input string name);
    if (act !== exp) begin
      $display("test failed");
      $display("error at %0t ns: %s expected %b actual %b", $time, name, exp, act);
      $fatal(1);
    end
  endtask

  task automatic check_idle();
    check_bit(1'b0, sdp2mcif_wr_req_valid, "sdp2mcif_wr_req_valid");
    check_bit(1'b0, sdp_dp2wdma_ready, "sdp_dp2wdma_ready");
    check_bit(1'b0, dp2reg_done, "dp2reg_done");
    check_bit(1'b0, sdp2glb_done_intr_pd[0], "sdp2glb_done_intr_pd[0]");
    check_bit(1'b0, sdp2glb_done_intr_pd[1], "sdp2glb_done_intr_pd[1]");
  endtask

  // surface-major line walk, each line command followed by its atoms
  task automatic build_expected(input case_t c);
    int        nsurf;
    dma_addr_t addr;
    wr_req_t   pkt;
    atom_t     a;
    nsurf = int'(c.channel >> 3) + 1;
    for (int s = 0; s < nsurf; s++) begin
      for (int l = 0; l <= int'(c.height); l++) begin
        addr = dma_addr_t'(c.base + s * c.surf_stride + l * c.line_stride);
        pkt = '0;
        pkt.ack = (s == nsurf - 1) && (l == int'(c.height));
        pkt.payload[`SDP_WDMA_ADDR_W-1:0] = addr;
        pkt.payload[`SDP_WDMA_ADDR_W+`SDP_WDMA_DIM_W-1:`SDP_WDMA_ADDR_W] = c.width;
        exp_q.push_back(pkt);
        for (int b = 0; b <= int'(c.width); b++) begin
          a = {xorshift_next(), xorshift_next()};
          atom_q.push_back(a);
          pkt = '0;
          pkt.kind = 1'b1;
          pkt.payload = a;
          exp_q.push_back(pkt);
        end
      end
    end
  endtask

  // memory side, one packet per accept
  task automatic accept_packet(input wr_req_t pkt);
    if (exp_q.size() == 0) begin
      stop_run("memory received a packet that was not expected");
    end else begin
      check_req(exp_q.pop_front(), pkt, "sdp2mcif_wr_req_pd");
      if (!pkt.kind && pkt.ack) begin
        ack_left = int'(pkt.payload[`SDP_WDMA_ADDR_W+`SDP_WDMA_DIM_W-1:`SDP_WDMA_ADDR_W]) + 1;
      end else if (pkt.kind && ack_left > 0) begin
        ack_left--;
        if (ack_left == 0) begin
          rsp_due++;  // last beat of the ack line taken
        end
      end
    end
  endtask

  // ====================
  // driver, stream source and memory
  // ====================
  always begin
    @(negedge autosa_core_clk);
    in_fire = sdp_dp2wdma_valid && sdp_dp2wdma_ready;
    @(posedge autosa_core_clk);
    #1;
    if (in_fire) begin
      void'(atom_q.pop_front());
    end
    if (!sdp_dp2wdma_valid || in_fire) begin
      sdp_dp2wdma_valid = (atom_q.size() > 0) && (xorshift_next() % 4 != 0);
      sdp_dp2wdma_pd    = (atom_q.size() > 0) ? atom_q[0] : '0;
    end
    mcif2sdp_wr_rsp_complete = 1'b0;
    if (rsp_wait > 0) begin
      rsp_wait--;
      if (rsp_wait == 0) begin
        mcif2sdp_wr_rsp_complete = 1'b1;
      end
    end
    if (rsp_due != rsp_taken) begin
      rsp_taken++;
      rsp_wait = rsp_lag - 1;
    end
    sdp2mcif_wr_req_ready = (xorshift_next() % 100) < ready_pct;
  end

  // ====================
  // monitor, sampled mid-cycle
  // ====================
  always @(negedge autosa_core_clk) begin
    if (mon_on) begin
      check_bit(prev_complete, dp2reg_done, "dp2reg_done");
      check_bit(prev_complete & reg2dp_interrupt_ptr, sdp2glb_done_intr_pd[1],
                "sdp2glb_done_intr_pd[1]");
      check_bit(prev_complete & ~reg2dp_interrupt_ptr, sdp2glb_done_intr_pd[0],
                "sdp2glb_done_intr_pd[0]");
      if (dp2reg_done && exp_q.size() != 0) begin
        stop_run("done arrived before all packets reached memory");
      end else if (dp2reg_done) begin
        done_cnt++;
      end
      if (tb_proc && reg2dp_perf_dma_en && sdp2mcif_wr_req_valid && !sdp2mcif_wr_req_ready) begin
        stall_model++;
      end
      if (sdp2mcif_wr_req_valid && sdp2mcif_wr_req_ready) begin
        accept_packet(sdp2mcif_wr_req_pd);
      end
      prev_complete = mcif2sdp_wr_rsp_complete;
      if (reg2dp_op_en && !tb_proc) begin
        tb_proc     = 1'b1;  // op_load cycle
        stall_model = 0;
      end else if (dp2reg_done) begin
        tb_proc = 1'b0;
      end
    end
  end

  // ====================
  // main sequence
  // ====================
  initial begin
    int n;
    int limit;
    int done_before;
    rng_state                 = 32'h3fd4b4ae;
    autosa_core_rstn          = 1'b0;
    reg2dp_op_en              = 1'b0;
    reg2dp_dst_base_addr      = '0;
    reg2dp_dst_line_stride    = '0;
    reg2dp_dst_surface_stride = '0;
    reg2dp_width              = '0;
    reg2dp_height             = '0;
    reg2dp_channel            = '0;
    reg2dp_interrupt_ptr      = 1'b0;
    reg2dp_perf_dma_en        = 1'b0;
    sdp_dp2wdma_valid         = 1'b0;
    sdp_dp2wdma_pd            = '0;
    sdp2mcif_wr_req_ready     = 1'b0;
    mcif2sdp_wr_rsp_complete  = 1'b0;
    ready_pct     = 7'd100;
    mon_on        = 1'b0;
    tb_proc       = 1'b0;
    prev_complete = 1'b0;
    in_fire       = 1'b0;
    done_cnt      = 0;
    stall_model   = 0;
    ack_left      = 0;
    rsp_due       = 0;
    rsp_taken     = 0;
    rsp_wait      = 0;
    // base, line stride, surface stride, width, height, channel, ptr, perf, ready %
    cases[0] = '{29'h100, 29'h10, 29'h80, 13'd3, 13'd2, 13'd15, 1'b0, 1'b1, 7'd60};
    cases[1] = '{29'h1ff_0000, 29'h7, 29'h40, 13'd0, 13'd4, 13'd7, 1'b1, 1'b1, 7'd40};
    cases[2] = '{29'h1fff_ff00, 29'h9, 29'h100, 13'd5, 13'd1, 13'd23, 1'b0, 1'b0, 7'd50};
    cases[3] = '{29'h2345, 29'h20, 29'h400, 13'd15, 13'd3, 13'd31, 1'b1, 1'b1, 7'd25};

    repeat (8) @(posedge autosa_core_clk);
    #1;
    autosa_core_rstn = 1'b1;
    tick();
    check_idle();
    mon_on = 1'b1;

    for (int i = 0; i < n_cases; i++) begin
      #2;
      build_expected(cases[i]);
      ready_pct   = cases[i].ready_pct;
      limit       = 200 + 20 * exp_q.size();
      done_before = done_cnt;
      tick();
      reg2dp_dst_base_addr      = cases[i].base;
      reg2dp_dst_line_stride    = cases[i].line_stride;
      reg2dp_dst_surface_stride = cases[i].surf_stride;
      reg2dp_width              = cases[i].width;
      reg2dp_height             = cases[i].height;
      reg2dp_channel            = cases[i].channel;
      reg2dp_interrupt_ptr      = cases[i].ptr;
      reg2dp_perf_dma_en        = cases[i].perf;
      reg2dp_op_en              = 1'b1;
      tick();
      reg2dp_op_en = 1'b0;
      n = 0;
      while (done_cnt == done_before && n < limit) begin
        tick();
        n++;
      end
      if (done_cnt == done_before) begin
        stop_run("timeout waiting for dp2reg_done");
      end else begin
        tick();  // done cycle has ended
        check_count(stall_model, dp2reg_status_wdma_stall, "dp2reg_status_wdma_stall");
        check_idle();
      end
    end

    if (done_cnt == n_cases && atom_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      stop_run("operation count or input stream does not match the case table");
    end
  end

endmodule

/* tb.f */
+incdir+hw
hw/sdp_wdma_pkg.sv
hw/sdp_wdma_fifo.sv
hw/sdp_wdma_cmd.sv
hw/sdp_wdma_dat.sv
hw/sdp_wdma_intr.sv
hw/sdp_wdma.sv
bench/sdp_wdma_tb.sv

/* Bender.yml */
package:
  name: sdp_wdma

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/sdp_wdma_pkg.sv
      - hw/sdp_wdma_fifo.sv
      - hw/sdp_wdma_cmd.sv
      - hw/sdp_wdma_dat.sv
      - hw/sdp_wdma_intr.sv
      - hw/sdp_wdma.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/sdp_wdma_tb.sv
